/* build.f */
+incdir+common
common/agu_pkg.sv
rtl/tile_geometry.sv
rtl/agu_control.sv
load_path/load_writer.sv
window_path/window_walker.sv
rtl/dataloader_agu.sv
sim/tb_dataloader_agu.sv

/* common/agu_config.svh */
`ifndef AGU_CONFIG_SVH
`define AGU_CONFIG_SVH

// --------------------
// array and datapath sizes
// --------------------
`define AGU_ARRAY_SIZE      8      // systolic array dimension
`define AGU_DATA_WIDTH      8      // one pixel or weight
`define AGU_WORD_WIDTH      32     // scratchpad word
`define AGU_BYTES_PER_WORD  4      // pixels packed per word
`define AGU_WORD_SHIFT      2      // byte index -> word index

// scratchpad is word addressed
`define AGU_ADDR_WIDTH      12

// --------------------
// scratchpad region map
// --------------------
`define AGU_WEIGHT_BASE     12'h000  // weights always start at word 0
`define AGU_INPUT_BASE_0    12'h080  // input bank 0
`define AGU_INPUT_BASE_1    12'h100  // input bank 1, ping-pong with bank 0

// 8-bit pixels in a 32-bit word, keep these two consistent
// with AGU_BYTES_PER_WORD when the word width changes

`endif

/* common/agu_pkg.sv */
`include "agu_config.svh"

package agu_pkg;

    // --------------------
    // vectors with a meaning
    // --------------------
    typedef logic [`AGU_ADDR_WIDTH-1:0]     sram_addr_t;   // word address
    typedef logic [`AGU_WORD_WIDTH-1:0]     sram_word_t;   // one scratchpad word
    typedef logic [`AGU_BYTES_PER_WORD-1:0] sram_mask_t;   // byte write mask
    typedef logic [6:0]                     dim_n_t;       // image side N
    typedef logic [4:0]                     dim_k_t;       // kernel side K
    typedef logic [7:0]                     tile_dim_t;    // input tile side
    typedef logic [15:0]                    pixel_count_t; // bytes, pixels or words

    // command modes, code 4 (old unload) and up are ignored
    typedef enum logic [2:0] {
        idle        = 3'd0,
        load_weight = 3'd1,
        load_input  = 3'd2,
        sliding_win = 3'd3
    } agu_mode_e;

    typedef enum logic [1:0] {
        st_idle,
        st_load,    // weight or input copy from rx
        st_stream,  // sliding window reads
        st_done
    } agu_state_e;

    // --------------------
    // bundles
    // --------------------
    typedef struct packed {
        tile_dim_t    tile_size;     // ARRAY_SIZE + K - 1
        pixel_count_t input_pixels;  // tile_size squared
        pixel_count_t input_words;   // ceil(input_pixels / 4)
        pixel_count_t weight_words;  // ceil(K*K / 4)
    } tile_geom_t;

    typedef struct packed {
        logic       wen;
        logic       ren;
        sram_mask_t wmask;
        sram_addr_t addr;
        sram_word_t din;
    } sram_req_t;

endpackage

/* load_path/load_writer.sv */
`timescale 1ns/10ps

module load_writer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load_go,
    input  agu_pkg::pixel_count_t load_limit,
    input  agu_pkg::sram_addr_t   base,
    input  agu_pkg::sram_word_t   rx_data,
    input  logic                  rx_valid,
    output logic                  rx_ready,
    output agu_pkg::sram_req_t    load_req,
    output logic                  load_last
);

    import agu_pkg::*;

    pixel_count_t word_ptr;     // words taken so far
    pixel_count_t next_ptr;
    logic         accept;       // rx handshake
    logic         final_word;

    assign accept     = rx_valid && rx_ready;
    assign next_ptr   = word_ptr + pixel_count_t'(1);
    assign final_word = (next_ptr == load_limit);   // single end test

    // --------------------
    // rx to scratchpad
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_ready  <= 1'b0;
            word_ptr  <= '0;
            load_req  <= '0;
            load_last <= 1'b0;
        end else begin
            load_req  <= '0;   // idle request unless a word lands
            load_last <= 1'b0;
            if (load_go) begin
                rx_ready <= 1'b1;   // open the stream
                word_ptr <= '0;
            end else if (accept) begin
                load_req.wen   <= 1'b1;
                load_req.wmask <= '1;   // whole word, 4 packed bytes
                load_req.addr  <= base + sram_addr_t'(word_ptr);
                load_req.din   <= rx_data;
                word_ptr       <= next_ptr;
                if (final_word) begin
                    rx_ready  <= 1'b0;   // exactly load_limit words
                    load_last <= 1'b1;   // lines up with the last write
                end
            end
        end
    end

    // rx_valid low just stalls the copy, nothing else to track

endmodule

/* rtl/agu_control.sv */
`timescale 1ns/10ps
`include "agu_config.svh"

module agu_control (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  agu_enable,
    input  logic                  agu_start,
    input  agu_pkg::agu_mode_e    agu_mode,
    input  logic                  bank_sel,
    input  agu_pkg::tile_geom_t   geom,
    input  logic                  load_last,
    input  logic                  window_last,
    input  agu_pkg::sram_req_t    load_req,
    input  agu_pkg::sram_req_t    win_req,
    output logic                  load_go,
    output logic                  stream_go,
    output agu_pkg::pixel_count_t load_limit,
    output agu_pkg::sram_addr_t   base,
    output logic                  agu_done,
    output agu_pkg::sram_req_t    sram_req
);

    import agu_pkg::*;

    agu_state_e state, next_state;
    logic       start_ok;   // qualified start strobe

    assign start_ok  = (state == st_idle) && agu_enable && agu_start;
    // go pulses land in the start cycle so the units are armed with the state change
    assign load_go   = start_ok && ((agu_mode == load_weight) || (agu_mode == load_input));
    assign stream_go = start_ok && (agu_mode == sliding_win);

    // --------------------
    // mode FSM
    // --------------------
    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (load_go)
                    next_state = st_load;
                else if (stream_go)
                    next_state = st_stream;   // anything else stays idle
            end
            st_load:   if (load_last)   next_state = st_done;
            st_stream: if (window_last) next_state = st_done;
            st_done:   next_state = st_idle;
            default:   next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            agu_done <= 1'b0;
        end else begin
            state    <= next_state;
            agu_done <= (state == st_done);   // one cycle after st_done
        end
    end

    // region base and word count, held for the whole command
    always_ff @(posedge clk) begin
        if (start_ok) begin
            if (agu_mode == load_weight) begin
                base       <= `AGU_WEIGHT_BASE;
                load_limit <= geom.weight_words;
            end else begin
                base       <= bank_sel ? `AGU_INPUT_BASE_1 : `AGU_INPUT_BASE_0;
                load_limit <= geom.input_words;   // unused by stream
            end
        end
    end

    // only the active unit reaches the scratchpad
    always_comb begin
        case (state)
            st_load:   sram_req = load_req;
            st_stream: sram_req = win_req;
            default:   sram_req = '0;
        endcase
    end

endmodule

/* rtl/dataloader_agu.sv */
`timescale 1ns/10ps

module dataloader_agu (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                agu_enable,
    input  logic                agu_start,
    input  agu_pkg::agu_mode_e  agu_mode,
    input  agu_pkg::dim_n_t     latched_N,   // kept for port compatibility, no tiling here
    input  agu_pkg::dim_k_t     latched_K,
    input  logic                bank_sel,
    input  logic                mem_read_en,
    input  agu_pkg::sram_word_t rx_data,
    input  logic                rx_valid,
    output logic                rx_ready,
    output logic                agu_done,
    output agu_pkg::sram_req_t  sram_req
);

    import agu_pkg::*;

    // --------------------
    // internal links
    // --------------------
    tile_geom_t   geom;
    logic         load_go, stream_go;
    logic         load_last, window_last;
    pixel_count_t load_limit;
    sram_addr_t   base;
    sram_req_t    load_req, win_req;

    tile_geometry tile_geometry_inst (.latched_K(latched_K), .geom(geom));

    agu_control agu_control_inst (
        .clk(clk), .rst_n(rst_n), .agu_enable(agu_enable), .agu_start(agu_start),
        .agu_mode(agu_mode), .bank_sel(bank_sel), .geom(geom),
        .load_last(load_last), .window_last(window_last),
        .load_req(load_req), .win_req(win_req), .load_go(load_go), .stream_go(stream_go),
        .load_limit(load_limit), .base(base), .agu_done(agu_done), .sram_req(sram_req)
    );

    load_writer load_writer_inst (
        .clk(clk), .rst_n(rst_n), .load_go(load_go), .load_limit(load_limit), .base(base),
        .rx_data(rx_data), .rx_valid(rx_valid), .rx_ready(rx_ready),
        .load_req(load_req), .load_last(load_last)
    );

    window_walker window_walker_inst (
        .clk(clk), .rst_n(rst_n), .stream_go(stream_go), .base(base), .geom(geom),
        .mem_read_en(mem_read_en), .win_req(win_req), .window_last(window_last)
    );

endmodule

/* rtl/tile_geometry.sv */
`timescale 1ns/10ps
`include "agu_config.svh"

module tile_geometry (
    input  agu_pkg::dim_k_t     latched_K,
    output agu_pkg::tile_geom_t geom
);

    import agu_pkg::*;

    // rounding term for the ceiling divide by bytes per word
    localparam pixel_count_t round_up = pixel_count_t'(`AGU_BYTES_PER_WORD - 1);

    tile_dim_t    tile_size;
    pixel_count_t input_pixels;
    pixel_count_t weight_pixels;

    // input tile needs K-1 extra rows and cols of halo
    assign tile_size = tile_dim_t'(`AGU_ARRAY_SIZE) + tile_dim_t'(latched_K)
                     - tile_dim_t'(1);

    // square tiles, one byte per pixel
    assign input_pixels  = pixel_count_t'(tile_size) * pixel_count_t'(tile_size);
    assign weight_pixels = pixel_count_t'(latched_K) * pixel_count_t'(latched_K);

    // --------------------
    // pack the result
    // --------------------
    always_comb begin
        geom.tile_size    = tile_size;
        geom.input_pixels = input_pixels;
        // partial last word still needs a full transfer
        geom.input_words  = (input_pixels + round_up) >> `AGU_WORD_SHIFT;
        geom.weight_words = (weight_pixels + round_up) >> `AGU_WORD_SHIFT;
    end

    // K=3 -> side 10, 100 pixels, 25 input words, 3 weight words

endmodule

/* run_sim.sh */
#!/bin/sh
# compile RTL and testbench with Verilator, run, then scan the log

cd "$(dirname "$0")" || exit 1

TOP=tb_dataloader_agu
LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps \
    -f build.f --top-module "$TOP" -Mdir obj_dir > build.log 2>&1 \
    || { echo "compile failed, see build.log"; exit 1; }

./obj_dir/V"$TOP" > "$LOG" 2>&1

grep -q "Some tests failed" "$LOG" && { echo "FAIL, see $LOG"; exit 1; }
grep -q "All tests passed" "$LOG" || { echo "FAIL, no result in $LOG"; exit 1; }
echo "PASS"

/* sim/tb_dataloader_agu.sv */
`timescale 1ns/10ps
`include "agu_config.svh"

module tb_dataloader_agu;

    import agu_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        agu_enable, agu_start, bank_sel, mem_read_en, rx_valid;
    agu_mode_e   agu_mode;
    dim_n_t      latched_N;
    dim_k_t      latched_K;
    sram_word_t  rx_data;
    logic        rx_ready, agu_done;
    sram_req_t   sram_req;

    sram_word_t  sram_mem [0:(1 << `AGU_ADDR_WIDTH) - 1];   // scratchpad model
    sram_req_t   writes[$];     // write requests in issue order
    sram_addr_t  reads[$];      // read addresses in issue order
    int unsigned done_count;
    logic        accepted_d;    // rx word taken on the previous edge
    logic        read_due;      // window step taken on the previous edge
    int unsigned steps_left;    // window steps the DUT still owes
    logic [31:0] lfsr_state;

    dataloader_agu dataloader_agu_inst (.*);

    always #2 clk = ~clk;   // 4 ns period

    // --------------------
    // bus monitor
    // --------------------
    always @(posedge clk) begin
        if (rst_n) begin
            check_bit("sram_req.wen", sram_req.wen, accepted_d);   // write one cycle after accept
            check_bit("sram_req.ren", sram_req.ren, read_due);     // read one cycle after a step
            if (sram_req.wen) begin
                sram_mem[sram_req.addr] = sram_req.din;
                writes.push_back(sram_req);
            end
            if (sram_req.ren)
                reads.push_back(sram_req.addr);
            if (agu_done)
                done_count++;
        end
        accepted_d = rx_valid && rx_ready;
        read_due   = mem_read_en && (steps_left != 0);
        if (read_due)
            steps_left--;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_addr(input string name, input sram_addr_t got, input sram_addr_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_word(input string name, input sram_word_t got, input sram_word_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, name, got, exp));
    endtask

    task automatic check_count(input string name, input pixel_count_t got,
                               input pixel_count_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    endtask

    // feedback taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic sram_word_t lfsr_word();
        sram_word_t w;
        for (int i = 0; i < 32; i++)
            w[i] = lfsr_bit();
        return w;
    endfunction

    task automatic clear_logs();
        @(negedge clk);
        writes.delete();
        reads.delete();
    endtask

    task automatic start_cmd(input agu_mode_e mode, input dim_k_t k, input logic bank,
                             input logic enable);
        @(posedge clk);
        agu_enable <= enable;
        agu_start  <= 1'b1;
        agu_mode   <= mode;
        latched_K  <= k;      // held after start so the geometry stays live
        bank_sel   <= bank;
        @(posedge clk);
        agu_start  <= 1'b0;
    endtask

    task automatic expect_quiet(input int cycles, input int unsigned done_exp);
        repeat (cycles) @(negedge clk);
        check_count("agu_done pulses", pixel_count_t'(done_count), pixel_count_t'(done_exp));
    endtask

    // --------------------
    // tests
    // --------------------
    task automatic reset_test();
        @(negedge clk);
        check_bit("rx_ready", rx_ready, 1'b0);
        check_bit("agu_done", agu_done, 1'b0);
        check_bit("sram_req.wen", sram_req.wen, 1'b0);
        check_bit("sram_req.ren", sram_req.ren, 1'b0);
        check_bit("sram_req.wmask any", |sram_req.wmask, 1'b0);
        check_addr("sram_req.addr", sram_req.addr, '0);
        check_word("sram_req.din", sram_req.din, '0);
    endtask

    task automatic ignored_start_test();
        clear_logs();
        start_cmd(load_weight, 5'd3, 1'b0, 1'b0);        // enable low
        expect_quiet(50, 0);
        start_cmd(agu_mode_e'(3'd4), 5'd3, 1'b0, 1'b1);  // old unload code
        expect_quiet(50, 0);
        check_count("writes after ignored starts", pixel_count_t'(writes.size()), '0);
        check_count("reads after ignored starts", pixel_count_t'(reads.size()), '0);
        check_bit("rx_ready", rx_ready, 1'b0);
    endtask

    task automatic load_test(input agu_mode_e mode, input dim_k_t k, input logic bank,
                             input sram_addr_t base, input int offer, input logic gaps);
        sram_word_t  words[$];
        int          side;
        int          expect_n;
        int          idx;
        int          cycles;
        int unsigned done_start;
        side = `AGU_ARRAY_SIZE + int'(k) - 1;
        // ceiling of bytes over four
        expect_n = (mode == load_weight) ? (int'(k) * int'(k) + 3) / 4 : (side * side + 3) / 4;
        for (int i = 0; i < offer; i++)
            words.push_back(lfsr_word());
        idx = 0;
        cycles = 0;
        clear_logs();
        done_start = done_count;
        start_cmd(mode, k, bank, 1'b1);
        forever begin
            rx_valid <= (idx < offer) && (!gaps || lfsr_bit());
            rx_data  <= words[(idx < offer) ? idx : 0];
            @(negedge clk);
            if (rx_valid && rx_ready)
                idx++;   // taken on the coming edge
            if (done_count != done_start)
                break;
            cycles++;
            if (cycles > 400)
                abort_run("load did not finish, agu_done never pulsed");
            @(posedge clk);
        end
        @(posedge clk);
        rx_valid <= 1'b0;
        check_count("accepted words", pixel_count_t'(idx), pixel_count_t'(expect_n));
        check_count("write count", pixel_count_t'(writes.size()), pixel_count_t'(expect_n));
        for (int i = 0; i < expect_n; i++) begin
            check_addr("sram_req.addr", writes[i].addr, base + sram_addr_t'(i));
            check_bit("sram_req.wmask full", &writes[i].wmask, 1'b1);
            check_word("sram word", sram_mem[base + sram_addr_t'(i)], words[i]);
        end
        expect_quiet(10, done_start + 1);
        check_bit("rx_ready", rx_ready, 1'b0);
    endtask

    task automatic stream_test(input dim_k_t k, input logic bank, input sram_addr_t base);
        int          side;
        int          i;
        int          cycles;
        int unsigned done_start;
        side = `AGU_ARRAY_SIZE + int'(k) - 1;
        cycles = 0;
        clear_logs();
        done_start = done_count;
        steps_left = side * side;   // one read owed per tile pixel
        start_cmd(sliding_win, k, bank, 1'b1);
        forever begin
            mem_read_en <= lfsr_bit();
            @(negedge clk);
            if (done_count != done_start)
                break;
            cycles++;
            if (cycles > 1000)
                abort_run("stream did not finish, agu_done never pulsed");
            @(posedge clk);
        end
        @(posedge clk);
        mem_read_en <= 1'b0;
        check_count("window steps", pixel_count_t'(reads.size()), pixel_count_t'(side * side));
        check_count("writes during stream", pixel_count_t'(writes.size()), '0);
        i = 0;
        for (int row = 0; row < side; row++) begin
            for (int col = 0; col < side; col++) begin
                check_addr("sram_req.addr", reads[i],
                           base + sram_addr_t'((row * side + col) >> 2));
                i++;
            end
        end
        expect_quiet(10, done_start + 1);
    endtask

    initial begin
        lfsr_state  = 32'hc8c5_3017;
        clk         = 1'b0;
        rst_n       = 1'b0;
        agu_enable  = 1'b0;
        agu_start   = 1'b0;
        agu_mode    = idle;
        latched_N   = 7'd16;   // no effect on this unit
        latched_K   = 5'd3;
        bank_sel    = 1'b0;
        mem_read_en = 1'b0;
        rx_data     = '0;
        rx_valid    = 1'b0;
        accepted_d  = 1'b0;
        read_due    = 1'b0;
        steps_left  = 0;
        done_count  = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        reset_test();
        ignored_start_test();
        load_test(load_weight, 5'd3, 1'b0, `AGU_WEIGHT_BASE, 5, 1'b0);   // 3 of 5 words taken
        load_test(load_input, 5'd3, 1'b0, `AGU_INPUT_BASE_0, 25, 1'b1);
        load_test(load_input, 5'd3, 1'b1, `AGU_INPUT_BASE_1, 25, 1'b1);
        stream_test(5'd1, 1'b0, `AGU_INPUT_BASE_0);
        stream_test(5'd2, 1'b1, `AGU_INPUT_BASE_1);
        $display("All tests passed");
        $finish;
    end

endmodule

/* window_path/window_walker.sv */
`timescale 1ns/10ps
`include "agu_config.svh"

module window_walker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stream_go,
    input  agu_pkg::sram_addr_t base,
    input  agu_pkg::tile_geom_t geom,
    input  logic                mem_read_en,
    output agu_pkg::sram_req_t  win_req,
    output logic                window_last
);

    import agu_pkg::*;

    logic         active;       // between go and the final pixel
    tile_dim_t    win_row;
    tile_dim_t    win_col;
    pixel_count_t step_cnt;     // pixels issued
    pixel_count_t pixel_off;    // row-major byte offset in tile
    sram_addr_t   word_off;
    logic         step;
    logic         row_end;
    logic         final_pixel;

    assign step        = active && mem_read_en;
    assign pixel_off   = pixel_count_t'(win_row) * pixel_count_t'(geom.tile_size)
                       + pixel_count_t'(win_col);
    assign word_off    = sram_addr_t'(pixel_off >> `AGU_WORD_SHIFT);   // word holding pixel
    assign row_end     = (win_col == geom.tile_size - tile_dim_t'(1));
    assign final_pixel = (step_cnt == geom.input_pixels - pixel_count_t'(1));

    // --------------------
    // walk and read
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active      <= 1'b0;
            win_row     <= '0;
            win_col     <= '0;
            step_cnt    <= '0;
            win_req     <= '0;
            window_last <= 1'b0;
        end else begin
            win_req     <= '0;
            window_last <= 1'b0;
            if (stream_go) begin
                active   <= 1'b1;
                win_row  <= '0;
                win_col  <= '0;
                step_cnt <= '0;
            end else if (step) begin
                win_req.ren  <= 1'b1;
                win_req.addr <= base + word_off;   // same word repeats for 4 pixels
                step_cnt     <= step_cnt + pixel_count_t'(1);
                if (row_end) begin
                    win_col <= '0;
                    win_row <= win_row + tile_dim_t'(1);
                end else begin
                    win_col <= win_col + tile_dim_t'(1);
                end
                if (final_pixel) begin
                    active      <= 1'b0;
                    window_last <= 1'b1;   // with the last read
                end
            end
        end
    end

endmodule
